/* common/cpuPkg.sv */
package cpuPkg;

	// Core widths
	localparam int dataWidth = 64;
	localparam int instrWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int opcodeWidth = 11;
	localparam int numRegs = 2 ** regAddrWidth;

	// Data memory geometry, one doubleword per entry
	localparam int memWords = 16;
	localparam int memIdxWidth = $clog2(memWords);

	// Opcode match patterns for the top 11 instruction bits
	// Low bits marked ? are immediate or cond bits, don't care
	localparam logic [opcodeWidth-1:0] opAddi = 11'b1001000100?;
	localparam logic [opcodeWidth-1:0] opAdds = 11'b10101011000;
	localparam logic [opcodeWidth-1:0] opSubs = 11'b11101011000;
	localparam logic [opcodeWidth-1:0] opLdur = 11'b11111000010;
	localparam logic [opcodeWidth-1:0] opStur = 11'b11111000000;
	localparam logic [opcodeWidth-1:0] opB    = 11'b000101?????;
	localparam logic [opcodeWidth-1:0] opBlt  = 11'b01010100???;
	localparam logic [opcodeWidth-1:0] opBl   = 11'b100101?????;
	localparam logic [opcodeWidth-1:0] opBr   = 11'b11010110000;
	localparam logic [opcodeWidth-1:0] opCbz  = 11'b10110100???;

	// ALU operation codes
	localparam int aluOpWidth = 3;
	localparam logic [aluOpWidth-1:0] aluPassB = 3'b000;
	localparam logic [aluOpWidth-1:0] aluAdd   = 3'b010;
	localparam logic [aluOpWidth-1:0] aluSub   = 3'b011;

	// B.cond field value for LT
	localparam logic [4:0] condLt = 5'h0B;

	// Special registers
	localparam logic [regAddrWidth-1:0] linkReg = 5'd30;
	localparam logic [regAddrWidth-1:0] zeroReg = 5'd31;

	// Bit positions in the flag word
	localparam int flagWidth = 4;
	localparam int flagN = 3;
	localparam int flagZ = 2;
	localparam int flagC = 1;
	localparam int flagV = 0;

	// Next-PC source select
	localparam logic [1:0] pcSeq = 2'd0;
	localparam logic [1:0] pcRel = 2'd1;
	localparam logic [1:0] pcReg = 2'd2;

endpackage

/* datapath/alu.sv */
`timescale 1ns/1ps

module alu
	import cpuPkg::*;
(
	input  logic [dataWidth-1:0]  a,
	input  logic [dataWidth-1:0]  b,
	input  logic [aluOpWidth-1:0] aluOp,
	output logic [dataWidth-1:0]  result,
	output logic [flagWidth-1:0]  flags,
	output logic                  zero
);

	localparam int msb = dataWidth - 1;

	logic carryIn;
	logic arith;
	logic [dataWidth-1:0] bOp;
	// One extra bit for carry out
	logic [dataWidth:0] sum;

	// Subtract as a + ~b + 1, so carry set means no borrow
	assign carryIn = (aluOp == aluSub);
	assign bOp = carryIn ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, bOp} + {{dataWidth{1'b0}}, carryIn};

	assign arith = (aluOp == aluAdd) || (aluOp == aluSub);

	always_comb begin
		case (aluOp)
			aluAdd, aluSub: result = sum[msb:0];
			aluPassB:       result = b;
			default:        result = '0;
		endcase
	end

	assign zero = (result == '0);

	// LEGv8 flags, C and V only for add/sub
	always_comb begin
		flags[flagN] = result[msb];
		flags[flagZ] = zero;
		flags[flagC] = arith & sum[dataWidth];
		// Same-sign operands giving a different-sign result
		flags[flagV] = arith & (a[msb] == bOp[msb]) & (result[msb] != a[msb]);
	end

endmodule

/* datapath/dataMem.sv */
`timescale 1ns/1ps

module dataMem
	import cpuPkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 wrEn,
	input  logic [dataWidth-1:0] addr,
	input  logic [dataWidth-1:0] wrData,
	output logic [dataWidth-1:0] rdData
);

	logic [dataWidth-1:0] mem [memWords];
	// Doubleword index, byte offset bits dropped
	logic [memIdxWidth-1:0] idx;

	assign idx = addr[memIdxWidth+2:3];

	always_ff @(posedge clk) begin
		if (wrEn && !reset) begin
			mem[idx] <= wrData;
		end
	end

	// Combinational read for single-cycle LDUR
	assign rdData = mem[idx];

	// Stores must be doubleword aligned
	assert property (@(posedge clk) disable iff (reset) wrEn |-> addr[2:0] == 3'b000)
		else $error("dataMem: unaligned store to %h", addr);

endmodule

/* datapath/dataPath.sv */
`timescale 1ns/1ps

module dataPath
	import cpuPkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic [instrWidth-1:0]   instr,
	input  logic [dataWidth-1:0]    pc,
	input  logic                    reg2Loc,
	input  logic                    aluSrc,
	input  logic                    memToReg,
	input  logic                    regWrite,
	input  logic                    memWrite,
	input  logic                    flagWrEn,
	input  logic                    rdX30,
	input  logic [aluOpWidth-1:0]   aluOp,
	output logic [flagWidth-1:0]    aluFlags,
	output logic                    aluZero,
	output logic [dataWidth-1:0]    regTarget,
	output logic                    regWrEn,
	output logic [regAddrWidth-1:0] regWrAddr,
	output logic [dataWidth-1:0]    regWrData,
	output logic                    memWrEn,
	output logic [dataWidth-1:0]    memAddr,
	output logic [dataWidth-1:0]    memWrData
);

	// Instruction fields
	logic [regAddrWidth-1:0] rd, rn, rm, rdAddrB;
	logic [11:0] imm12;
	logic [8:0] imm9;
	logic [dataWidth-1:0] rdDataA, rdDataB, immExt, aluB, aluResult, memRdData;

	assign rd = instr[4:0];
	assign rn = instr[9:5];
	assign rm = instr[20:16];
	assign imm12 = instr[21:10];
	assign imm9 = instr[20:12];

	// Rm for R-type, Rd for STUR, CBZ and BR
	assign rdAddrB = reg2Loc ? rm : rd;

	// reg2Loc only high with an immediate on ADDI, so it picks Imm12 over Imm9
	assign immExt = reg2Loc ? {{(dataWidth-12){1'b0}}, imm12}
	                        : {{(dataWidth-9){imm9[8]}}, imm9};
	assign aluB = aluSrc ? immExt : rdDataB;

	regFile regFile_inst (.clk(clk), .reset(reset), .wrEn(regWrEn), .rdAddrA(rn),
		.rdAddrB(rdAddrB), .wrAddr(regWrAddr), .wrData(regWrData),
		.rdDataA(rdDataA), .rdDataB(rdDataB));

	alu alu_inst (.a(rdDataA), .b(aluB), .aluOp(aluOp), .result(aluResult),
		.flags(aluFlags), .zero(aluZero));

	dataMem dataMem_inst (.clk(clk), .reset(reset), .wrEn(memWrEn), .addr(memAddr),
		.wrData(memWrData), .rdData(memRdData));

	// BR target is Rd read through port B
	assign regTarget = rdDataB;

	// Memory side
	assign memAddr = aluResult;
	assign memWrData = rdDataB;
	assign memWrEn = memWrite & ~reset;

	// Writeback, BL forces X30 and pc plus 4
	assign regWrEn = regWrite & ~reset;
	assign regWrAddr = rdX30 ? linkReg : rd;
	assign regWrData = rdX30 ? (pc + 64'd4) : (memToReg ? memRdData : aluResult);

	// Loads need an aligned address too
	assert property (@(posedge clk) disable iff (reset)
		(regWrEn && memToReg) |-> memAddr[2:0] == 3'b000)
		else $error("dataPath: unaligned load from %h", memAddr);

	// Flag-setting ops are register-register ALU writes
	assert property (@(posedge clk) disable iff (reset)
		flagWrEn |-> (regWrite && !memToReg && !aluSrc && !memWrite))
		else $error("dataPath: flag write with inconsistent controls");

endmodule

/* datapath/regFile.sv */
`timescale 1ns/1ps

module regFile
	import cpuPkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    wrEn,
	input  logic [regAddrWidth-1:0] rdAddrA,
	input  logic [regAddrWidth-1:0] rdAddrB,
	input  logic [regAddrWidth-1:0] wrAddr,
	input  logic [dataWidth-1:0]    wrData,
	output logic [dataWidth-1:0]    rdDataA,
	output logic [dataWidth-1:0]    rdDataB
);

	logic [dataWidth-1:0] regs [numRegs];

	// Single write port, X31 writes dropped
	always_ff @(posedge clk) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (wrEn && (wrAddr != zeroReg)) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Asynchronous reads, XZR always zero
	assign rdDataA = (rdAddrA == zeroReg) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == zeroReg) ? '0 : regs[rdAddrB];

endmodule

/* list.f */
+incdir+tests
common/cpuPkg.sv
datapath/regFile.sv
datapath/alu.sv
datapath/dataMem.sv
datapath/dataPath.sv
src/control.sv
src/branchUnit.sv
src/fetchUnit.sv
src/cpuTop.sv
tests/cpuTb.sv

/* run.sh */
#!/bin/sh
# Build and run the cpuTb simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module cpuTb -f list.f -o cpuSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/cpuSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Everything OK"; then
	exit 0
else
	exit 1
fi

/* src/branchUnit.sv */
`timescale 1ns/1ps

module branchUnit
	import cpuPkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 flagWrEn,
	input  logic                 isB,
	input  logic                 isBlt,
	input  logic                 isBl,
	input  logic                 isBr,
	input  logic                 isCbz,
	input  logic [4:0]           cond,
	input  logic [flagWidth-1:0] aluFlags,
	input  logic                 aluZero,
	output logic [1:0]           pcSel,
	output logic                 uncondBr
);

	// Stored N Z C V from the last flag-setting op
	logic [flagWidth-1:0] flagReg;
	logic ltTaken;
	logic relTaken;

	always_ff @(posedge clk) begin
		if (reset) begin
			flagReg <= '0;
		end else if (flagWrEn) begin
			flagReg <= aluFlags;
		end
	end

	// B and BL use the 26-bit displacement
	assign uncondBr = isB | isBl;

	// LT means N != V, read from the stored flags
	assign ltTaken = isBlt && (cond == condLt) && (flagReg[flagN] != flagReg[flagV]);

	// CBZ looks at the live ALU zero of Rd
	assign relTaken = uncondBr || ltTaken || (isCbz && aluZero);

	always_comb begin
		if (isBr) begin
			pcSel = pcReg;
		end else if (relTaken) begin
			pcSel = pcRel;
		end else begin
			pcSel = pcSeq;
		end
	end

	// Decoder must never raise two branch classes at once
	assert property (@(posedge clk) disable iff (reset)
		$onehot0({isB, isBlt, isBl, isBr, isCbz}))
		else $error("branchUnit: more than one branch class active");

endmodule

/* src/control.sv */
`timescale 1ns/1ps

module control
	import cpuPkg::*;
(
	input  logic [opcodeWidth-1:0] opcode,
	output logic                   reg2Loc,
	output logic                   aluSrc,
	output logic                   memToReg,
	output logic                   regWrite,
	output logic                   memWrite,
	output logic                   flagWrEn,
	output logic                   rdX30,
	output logic                   isB,
	output logic                   isBlt,
	output logic                   isBl,
	output logic                   isBr,
	output logic                   isCbz,
	output logic [aluOpWidth-1:0]  aluOp
);

	// Datapath word: reg2Loc aluSrc memToReg regWrite memWrite flagWrEn rdX30
	logic [6:0] ctrl;
	// Branch class word: B B.LT BL BR CBZ
	logic [4:0] brClass;

	assign {reg2Loc, aluSrc, memToReg, regWrite, memWrite, flagWrEn, rdX30} = ctrl;
	assign {isB, isBlt, isBl, isBr, isCbz} = brClass;

	// Priority decode, every arm fully defined
	always_comb begin
		casez (opcode)
			// reg2Loc high on ADDI picks the Imm12 path in the datapath
			opAddi: begin ctrl = 7'b1101000; aluOp = aluAdd; brClass = 5'b00000; end
			opAdds: begin ctrl = 7'b1001010; aluOp = aluAdd; brClass = 5'b00000; end
			opSubs: begin ctrl = 7'b1001010; aluOp = aluSub; brClass = 5'b00000; end
			// Loads and stores use sign-extended Imm9
			opLdur: begin ctrl = 7'b0111000; aluOp = aluAdd; brClass = 5'b00000; end
			// Store data comes out of port B as Rd
			opStur: begin ctrl = 7'b0100100; aluOp = aluAdd; brClass = 5'b00000; end
			opB:    begin ctrl = 7'b0000000; aluOp = aluPassB; brClass = 5'b10000; end
			opBlt:  begin ctrl = 7'b0000000; aluOp = aluPassB; brClass = 5'b01000; end
			// BL writes pc plus 4 into X30
			opBl:   begin ctrl = 7'b0001001; aluOp = aluPassB; brClass = 5'b00100; end
			// BR target is Rd through port B
			opBr:   begin ctrl = 7'b0000000; aluOp = aluPassB; brClass = 5'b00010; end
			// CBZ tests Rd, passed straight through the ALU
			opCbz:  begin ctrl = 7'b0000000; aluOp = aluPassB; brClass = 5'b00001; end
			// Unknown opcode, nothing written, pc just steps
			default: begin ctrl = 7'b0000000; aluOp = aluPassB; brClass = 5'b00000; end
		endcase
	end

endmodule

/* src/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop
	import cpuPkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic [instrWidth-1:0]   instr,
	output logic [dataWidth-1:0]    pc,
	output logic                    regWrEn,
	output logic [regAddrWidth-1:0] regWrAddr,
	output logic [dataWidth-1:0]    regWrData,
	output logic                    memWrEn,
	output logic [dataWidth-1:0]    memAddr,
	output logic [dataWidth-1:0]    memWrData
);

	// Decoder outputs
	logic reg2Loc, aluSrc, memToReg, regWrite, memWrite, flagWrEn, rdX30;
	logic isB, isBlt, isBl, isBr, isCbz;
	logic [aluOpWidth-1:0] aluOp;

	// Branch and next-PC wiring
	logic [1:0] pcSel;
	logic uncondBr;
	logic [flagWidth-1:0] aluFlags;
	logic aluZero;
	logic [dataWidth-1:0] regTarget;

	fetchUnit fetchUnit_inst (.clk(clk), .reset(reset), .instr(instr), .pcSel(pcSel),
		.uncondBr(uncondBr), .regTarget(regTarget), .pc(pc));

	// Opcode is the top 11 instruction bits
	control control_inst (.opcode(instr[instrWidth-1 -: opcodeWidth]), .reg2Loc(reg2Loc),
		.aluSrc(aluSrc), .memToReg(memToReg), .regWrite(regWrite), .memWrite(memWrite),
		.flagWrEn(flagWrEn), .rdX30(rdX30), .isB(isB), .isBlt(isBlt), .isBl(isBl),
		.isBr(isBr), .isCbz(isCbz), .aluOp(aluOp));

	// Cond field sits in the low five bits of B.cond
	branchUnit branchUnit_inst (.clk(clk), .reset(reset), .flagWrEn(flagWrEn), .isB(isB),
		.isBlt(isBlt), .isBl(isBl), .isBr(isBr), .isCbz(isCbz), .cond(instr[4:0]),
		.aluFlags(aluFlags), .aluZero(aluZero), .pcSel(pcSel), .uncondBr(uncondBr));

	dataPath dataPath_inst (.clk(clk), .reset(reset), .instr(instr), .pc(pc),
		.reg2Loc(reg2Loc), .aluSrc(aluSrc), .memToReg(memToReg), .regWrite(regWrite),
		.memWrite(memWrite), .flagWrEn(flagWrEn), .rdX30(rdX30), .aluOp(aluOp),
		.aluFlags(aluFlags), .aluZero(aluZero), .regTarget(regTarget),
		.regWrEn(regWrEn), .regWrAddr(regWrAddr), .regWrData(regWrData),
		.memWrEn(memWrEn), .memAddr(memAddr), .memWrData(memWrData));

endmodule

/* src/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit
	import cpuPkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic [instrWidth-1:0] instr,
	input  logic [1:0]            pcSel,
	input  logic                  uncondBr,
	input  logic [dataWidth-1:0]  regTarget,
	output logic [dataWidth-1:0]  pc
);

	logic [dataWidth-1:0] disp;
	logic [dataWidth-1:0] seqTarget;
	logic [dataWidth-1:0] relTarget;
	logic [dataWidth-1:0] nextPc;

	// Imm26 for B/BL, Imm19 at bits 23:5 for B.LT/CBZ
	assign disp = uncondBr ? {{(dataWidth-26){instr[25]}}, instr[25:0]}
	                       : {{(dataWidth-19){instr[23]}}, instr[23:5]};

	assign seqTarget = pc + 64'd4;
	// Word displacement, so shift into bytes
	assign relTarget = pc + (disp << 2);

	always_comb begin
		case (pcSel)
			pcRel:   nextPc = relTarget;
			pcReg:   nextPc = regTarget;
			default: nextPc = seqTarget;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= nextPc;
		end
	end

	// Instruction fetch needs a word-aligned pc, including BR targets
	assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("fetchUnit: pc not word aligned");

endmodule

/* tests/cpuTbTasks.svh */
`ifndef CPU_TB_TASKS_SVH
`define CPU_TB_TASKS_SVH

// Compare one DUT value with its expected value
task automatic checkEq(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
	if (actual !== expected) begin
		$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, actual,
			expected);
		$display("Something failed");
		$fatal(1, "stopping at first mismatch");
	end
endtask

// Galois LFSR, one step per returned bit
function automatic logic [63:0] randBits(input int n);
	logic [63:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		if (lfsrState[0]) begin
			lfsrState = (lfsrState >> 1) ^ 16'hB400;
		end else begin
			lfsrState = lfsrState >> 1;
		end
		v = {v[62:0], lfsrState[0]};
	end
	return v;
endfunction

// Instruction encoders, fixed opcode bits from the package patterns
function automatic logic [31:0] encAddi(input logic [4:0] rd, input logic [4:0] rn,
		input logic [11:0] imm);
	return {opAddi[10:1], imm, rn, rd};
endfunction

function automatic logic [31:0] encAdds(input logic [4:0] rd, input logic [4:0] rn,
		input logic [4:0] rm);
	return {opAdds, rm, 6'd0, rn, rd};
endfunction

function automatic logic [31:0] encSubs(input logic [4:0] rd, input logic [4:0] rn,
		input logic [4:0] rm);
	return {opSubs, rm, 6'd0, rn, rd};
endfunction

function automatic logic [31:0] encLdur(input logic [4:0] rt, input logic [4:0] rn,
		input logic [8:0] imm);
	return {opLdur, imm, 2'b00, rn, rt};
endfunction

function automatic logic [31:0] encStur(input logic [4:0] rt, input logic [4:0] rn,
		input logic [8:0] imm);
	return {opStur, imm, 2'b00, rn, rt};
endfunction

function automatic logic [31:0] encB(input logic [25:0] disp);
	return {opB[10:5], disp};
endfunction

function automatic logic [31:0] encBl(input logic [25:0] disp);
	return {opBl[10:5], disp};
endfunction

function automatic logic [31:0] encBlt(input logic [18:0] disp);
	return {opBlt[10:3], disp, condLt};
endfunction

function automatic logic [31:0] encCbz(input logic [4:0] rt, input logic [18:0] disp);
	return {opCbz[10:3], disp, rt};
endfunction

// Target register sits in the Rd field
function automatic logic [31:0] encBr(input logic [4:0] rt);
	return {opBr, 16'd0, rt};
endfunction

// XZR reads zero
function automatic logic [63:0] readReg(input logic [4:0] idx);
	return (idx == 5'd31) ? 64'd0 : mRegs[idx];
endfunction

// Reference model, one instruction per call
task automatic modelStep(input logic [31:0] ins);
	logic [10:0] op;
	logic [4:0] rd;
	logic [4:0] rn;
	logic [63:0] a;
	logic [63:0] b;
	logic [63:0] r;
	logic [64:0] wide;
	logic [63:0] addr;
	logic [63:0] nextPc;
	logic [63:0] rel19;
	logic [63:0] rel26;
	op = ins[31:21];
	rd = ins[4:0];
	rn = ins[9:5];
	a = readReg(rn);
	addr = a + {{55{ins[20]}}, ins[20:12]};
	rel19 = mPc + ({{45{ins[23]}}, ins[23:5]} << 2);
	rel26 = mPc + ({{38{ins[25]}}, ins[25:0]} << 2);
	nextPc = mPc + 64'd4;
	expRegWrEn = 1'b0;
	expRegWrAddr = rd;
	expRegWrData = '0;
	expMemWrEn = 1'b0;
	expMemAddr = '0;
	expMemWrData = '0;
	if (op[10:1] == opAddi[10:1]) begin
		expRegWrEn = 1'b1;
		expRegWrData = a + {52'd0, ins[21:10]};
	end else if (op == opAdds || op == opSubs) begin
		b = readReg(ins[20:16]);
		if (op == opAdds) begin
			wide = {1'b0, a} + {1'b0, b};
			r = wide[63:0];
			mV = (a[63] == b[63]) && (r[63] != a[63]);
		end else begin
			r = a - b;
			mV = (a[63] != b[63]) && (r[63] != a[63]);
		end
		mN = r[63];
		expRegWrEn = 1'b1;
		expRegWrData = r;
	end else if (op == opLdur) begin
		expRegWrEn = 1'b1;
		expRegWrData = mMem[addr[6:3]];
	end else if (op == opStur) begin
		expMemWrEn = 1'b1;
		expMemAddr = addr;
		expMemWrData = readReg(rd);
	end else if (op[10:5] == opB[10:5]) begin
		nextPc = rel26;
	end else if (op[10:5] == opBl[10:5]) begin
		expRegWrEn = 1'b1;
		expRegWrAddr = linkReg;
		expRegWrData = mPc + 64'd4;
		nextPc = rel26;
	end else if (op[10:3] == opBlt[10:3]) begin
		// LT taken when N and V differ
		if (ins[4:0] == condLt && mN != mV) begin
			nextPc = rel19;
		end
	end else if (op == opBr) begin
		nextPc = readReg(rd);
	end else if (op[10:3] == opCbz[10:3]) begin
		if (readReg(rd) == 64'd0) begin
			nextPc = rel19;
		end
	end
	// Commit model state
	if (expRegWrEn && expRegWrAddr != 5'd31) begin
		mRegs[expRegWrAddr] = expRegWrData;
	end
	if (expMemWrEn) begin
		mMem[expMemAddr[6:3]] = expMemWrData;
	end
	mPc = nextPc;
endtask

`endif

/* tests/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb
	import cpuPkg::*;
();

	localparam int resetCycles = 16;
	localparam int maxSteps = 64;
	localparam int numRuns = 7;
	// Each run is a reset plus at most maxSteps instructions
	localparam int timeoutNs = numRuns * (resetCycles + maxSteps + 4) * 4 + 100;

	logic clk;
	logic reset;
	logic [31:0] instr;
	logic [63:0] pc;
	logic regWrEn;
	logic [4:0] regWrAddr;
	logic [63:0] regWrData;
	logic memWrEn;
	logic [63:0] memAddr;
	logic [63:0] memWrData;

	// Instruction memory
	logic [31:0] prog [64];

	// Model state
	logic [63:0] mRegs [32];
	logic [63:0] mMem [memWords];
	logic [63:0] mPc;
	logic mN;
	logic mV;
	logic [15:0] lfsrState = 16'd21;

	// Expected observation ports
	logic expRegWrEn;
	logic [4:0] expRegWrAddr;
	logic [63:0] expRegWrData;
	logic expMemWrEn;
	logic [63:0] expMemAddr;
	logic [63:0] expMemWrData;

	`include "cpuTbTasks.svh"

	cpuTop cpuTop_inst (.clk(clk), .reset(reset), .instr(instr), .pc(pc),
		.regWrEn(regWrEn), .regWrAddr(regWrAddr), .regWrData(regWrData),
		.memWrEn(memWrEn), .memAddr(memAddr), .memWrData(memWrData));

	always #2 clk = ~clk;

	// Watchdog
	initial begin
		#(timeoutNs);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

	// Unused slots hold an unknown opcode
	task automatic clearProgram();
		for (int i = 0; i < 64; i++) begin
			prog[i] = 32'h0000_0000;
		end
	endtask

	// Reset DUT and model, write enables must stay low
	task automatic applyReset();
		repeat (resetCycles) begin
			@(negedge clk);
			reset = 1'b1;
			instr = prog[0];
			#1;
			checkEq(64'(regWrEn), 64'd0, "regWrEn during reset");
			checkEq(64'(memWrEn), 64'd0, "memWrEn during reset");
		end
		for (int i = 0; i < 32; i++) begin
			mRegs[i] = '0;
		end
		mPc = '0;
		mN = 1'b0;
		mV = 1'b0;
	endtask

	// Step until the model reaches the end of the program
	task automatic runProgram(input int len);
		int steps;
		steps = 0;
		while (mPc != 64'(len * 4)) begin
			if (steps >= maxSteps) begin
				$display("Program did not reach its end within %0d steps", maxSteps);
				$display("Something failed");
				$fatal(1, "runaway program");
			end
			@(negedge clk);
			reset = 1'b0;
			instr = prog[mPc[7:2]];
			#1;
			checkEq(pc, mPc, "pc");
			modelStep(instr);
			checkEq(64'(regWrEn), 64'(expRegWrEn), "regWrEn");
			if (expRegWrEn) begin
				checkEq(64'(regWrAddr), 64'(expRegWrAddr), "regWrAddr");
				checkEq(regWrData, expRegWrData, "regWrData");
			end
			checkEq(64'(memWrEn), 64'(expMemWrEn), "memWrEn");
			if (expMemWrEn) begin
				checkEq(memAddr, expMemAddr, "memAddr");
				checkEq(memWrData, expMemWrData, "memWrData");
			end
			steps++;
		end
		// Last pc update, then park on a no-op
		@(negedge clk);
		instr = 32'h0000_0000;
		#1;
		checkEq(pc, mPc, "final pc");
	endtask

	// Dirty registers, flags and pc, then check that reset clears them
	task automatic resetTest();
		clearProgram();
		prog[0] = encAddi(5'd0, 5'd31, 12'h5A5);
		prog[1] = encAddi(5'd30, 5'd31, 12'h3C3);
		// 0 - X0 leaves N set and V clear
		prog[2] = encSubs(5'd29, 5'd31, 5'd0);
		applyReset();
		runProgram(3);
		clearProgram();
		prog[0] = encStur(5'd0, 5'd31, 9'd8);
		prog[1] = encStur(5'd30, 5'd31, 9'd16);
		// Cleared flags make this B.LT fall through
		prog[2] = encBlt(19'd2);
		applyReset();
		runProgram(3);
	endtask

	// Random ADDI, then ADDS/SUBS, flags seen through B.LT
	task automatic aluTest();
		clearProgram();
		prog[0] = encAddi(5'd1, 5'd31, 12'(randBits(12)));
		prog[1] = encAddi(5'd2, 5'd31, 12'(randBits(12)));
		prog[2] = encAdds(5'd3, 5'd1, 5'd2);
		prog[3] = encSubs(5'd4, 5'd1, 5'd2);
		prog[4] = encBlt(19'd2);
		prog[5] = encAddi(5'd5, 5'd31, 12'd1);
		prog[6] = encAddi(5'd6, 5'd31, 12'd2);
		prog[7] = encSubs(5'd7, 5'd2, 5'd1);
		prog[8] = encBlt(19'd2);
		prog[9] = encAddi(5'd8, 5'd31, 12'd3);
		prog[10] = encAddi(5'd9, 5'd31, 12'd4);
		// Negative result against the zero register
		prog[11] = encSubs(5'd10, 5'd31, 5'd1);
		prog[12] = encBlt(19'd2);
		prog[13] = encAddi(5'd11, 5'd31, 12'd5);
		applyReset();
		runProgram(14);
	endtask

	// Store then load at random aligned addresses around base 64
	task automatic memTest();
		int off;
		logic [4:0] dataReg;
		logic [4:0] loadReg;
		clearProgram();
		prog[0] = encAddi(5'd1, 5'd31, 12'd64);
		for (int k = 0; k < 4; k++) begin
			off = int'(randBits(4)) * 8 - 64;
			dataReg = 5'd2 + 5'(randBits(3));
			loadReg = 5'd16 + 5'(randBits(3));
			prog[1 + 3 * k] = encAddi(dataReg, 5'd31, 12'(randBits(12)));
			prog[2 + 3 * k] = encStur(dataReg, 5'd1, 9'(off));
			prog[3 + 3 * k] = encLdur(loadReg, 5'd1, 9'(off));
		end
		applyReset();
		runProgram(13);
	endtask

	// B, CBZ taken and not taken, BR
	task automatic branchTest();
		clearProgram();
		prog[0] = encAddi(5'd1, 5'd31, 12'd5);
		prog[1] = encB(26'd2);
		prog[2] = encAddi(5'd2, 5'd31, 12'd1);
		prog[3] = encCbz(5'd31, 19'd2);
		prog[4] = encAddi(5'd3, 5'd31, 12'd1);
		prog[5] = encCbz(5'd1, 19'd2);
		prog[6] = encAddi(5'd4, 5'd31, 12'd40);
		prog[7] = encBr(5'd4);
		prog[8] = encAddi(5'd5, 5'd31, 12'd1);
		prog[9] = encAddi(5'd5, 5'd31, 12'd2);
		prog[10] = encAddi(5'd6, 5'd31, 12'd7);
		applyReset();
		runProgram(11);
	endtask

	// BL into a subroutine, BR X30 back
	task automatic linkTest();
		clearProgram();
		prog[0] = encBl(26'd3);
		prog[1] = encAddi(5'd2, 5'd31, 12'd9);
		prog[2] = encB(26'd3);
		prog[3] = encAddi(5'd1, 5'd31, 12'd3);
		prog[4] = encBr(linkReg);
		applyReset();
		runProgram(5);
	endtask

	// Unknown opcodes and writes to X31
	task automatic unknownTest();
		clearProgram();
		prog[0] = encAddi(5'd31, 5'd31, 12'(randBits(12)));
		prog[1] = 32'h0000_0000;
		prog[2] = 32'hFFFF_FFFF;
		prog[3] = encStur(5'd31, 5'd31, 9'd0);
		prog[4] = encAdds(5'd2, 5'd31, 5'd31);
		applyReset();
		runProgram(5);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instr = '0;
		for (int i = 0; i < memWords; i++) begin
			mMem[i] = '0;
		end
		resetTest();
		aluTest();
		memTest();
		branchTest();
		linkTest();
		unknownTest();
		$display("Everything OK");
		$finish;
	end

endmodule
